/* rtl/e300_ctrl_consts.svh */
/*
 * Register map, readback map and fixed values of the transceiver control plane.
 * Include wherever an address or reset value is decoded.
 */
`ifndef E300_CTRL_CONSTS_SVH
`define E300_CTRL_CONSTS_SVH

// global settings registers
`define SR_CORE_READBACK  8'd0
`define SR_CORE_MISC      8'd4
`define SR_CORE_TEST      8'd28

// radio windows, four words each
`define SR_RADIO0_BASE    8'd64
`define SR_RADIO1_BASE    8'd96
`define SR_RADIO_MISC     8'd0
`define SR_RADIO_LEDS     8'd1
`define SR_RADIO_GPIO     8'd2
`define SR_RADIO_SPI      8'd3

// readback select values
`define RB_CORE_MISC      8'd1
`define RB_CORE_COMPAT    8'd2
`define RB_CORE_PLL       8'd4
`define RB_RADIO0_SPI     8'd16
`define RB_RADIO1_SPI     8'd17
`define RB_CORE_TEST      8'd24

`define CORE_COMPAT_VALUE 32'hAC00FF00
`define RB_DEFAULT        32'hDEADBEEF
// internal pps selected out of reset
`define MISC_RESET        32'd2
// bus_clk cycles per sclk half period
`define SPI_CLKDIV        2

`endif

/* rtl/e300_ctrl_pkg.sv */
/*
 * Shared types of the control plane: word widths, settings-bus beat,
 * SPI request/response records and the SPI engine states.
 */
package e300_ctrl_pkg;

  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] reg_word_t;
  typedef logic [15:0] spi_word_t;

  // one settings-bus write beat
  typedef struct packed {
    logic      stb;
    set_addr_t addr;
    reg_word_t data;
  } set_bus_t;

  // pending transfer from a radio
  typedef struct packed {
    logic      valid;
    spi_word_t wdata;
  } spi_req_t;

  // done is a single-cycle strobe
  typedef struct packed {
    logic      done;
    spi_word_t rdata;
  } spi_rsp_t;

  typedef enum logic [1:0] {
    idle,
    shift_lo,
    shift_hi,
    finish
  } spi_state_e;

endpackage

/* rtl/core_regs.sv */
/*
 * Global settings registers, PLL lock synchronizer and the readback mux.
 * Sits on the shared settings bus next to the two radio blocks.
 */
`timescale 1ns/1ns
`include "e300_ctrl_consts.svh"

module core_regs
  import e300_ctrl_pkg::*;
(
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  input  set_bus_t  i_set,
  input  logic [1:0] i_lock_signals,
  input  logic [3:0] i_tcxo_status,
  input  reg_word_t i_radio0_rb,
  input  reg_word_t i_radio1_rb,
  output logic [1:0] o_pps_select,
  output logic      o_mimo,
  output logic      o_codec_arst,
  output reg_word_t o_rb_data
);

  set_addr_t  rb_addr;
  reg_word_t  test_reg;
  reg_word_t  misc_reg;
  logic [1:0] lock_meta;
  logic [1:0] lock_sync;

  //////////////////////////////
  // settings registers
  //////////////////////////////

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      rb_addr  <= '0;
      test_reg <= '0;
      misc_reg <= `MISC_RESET;
    end else if (i_set.stb) begin
      case (i_set.addr)
        `SR_CORE_READBACK: rb_addr  <= i_set.data[7:0];
        `SR_CORE_TEST:     test_reg <= i_set.data;
        `SR_CORE_MISC:     misc_reg <= i_set.data;
        // other addresses belong to the radios or to nobody
        default: ;
      endcase
    end
  end

  assign o_pps_select = misc_reg[1:0];
  assign o_mimo       = misc_reg[2];
  assign o_codec_arst = misc_reg[3];

  //////////////////////////////
  // lock synchronizer
  //////////////////////////////

  // two flops, locks come from the converter clock domain
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lock_meta <= '0;
      lock_sync <= '0;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  //////////////////////////////
  // readback mux
  //////////////////////////////

  always_comb begin
    case (rb_addr)
      `RB_CORE_MISC:   o_rb_data = {26'd0, i_tcxo_status, o_pps_select};
      `RB_CORE_COMPAT: o_rb_data = `CORE_COMPAT_VALUE;
      `RB_CORE_PLL:    o_rb_data = {30'd0, lock_sync};
      `RB_CORE_TEST:   o_rb_data = test_reg;
      `RB_RADIO0_SPI:  o_rb_data = i_radio0_rb;
      `RB_RADIO1_SPI:  o_rb_data = i_radio1_rb;
      default:         o_rb_data = `RB_DEFAULT;
    endcase
  end

endmodule

/* rtl/radio_ctrl.sv */
/*
 * Per-radio control registers: band select, LEDs, daughterboard GPIO and
 * an SPI request slot. Instantiate once per radio with its base address.
 */
`timescale 1ns/1ns
`include "e300_ctrl_consts.svh"

module radio_ctrl
  import e300_ctrl_pkg::*;
#(
  parameter set_addr_t RADIO_BASE = `SR_RADIO0_BASE
) (
  input  logic        i_bus_clk,
  input  logic        i_bus_rst,
  input  set_bus_t    i_set,
  input  spi_rsp_t    i_spi_rsp,
  output spi_req_t    o_spi_req,
  output logic [9:0]  o_bandsel,
  output logic [2:0]  o_leds,
  output reg_word_t   o_db_gpio,
  output reg_word_t   o_rb_word
);

  set_addr_t offset;
  logic      hit;
  logic      req_valid;
  spi_word_t req_wdata;
  spi_word_t rx_word;

  // word offset inside this radio's window
  assign offset = i_set.addr - RADIO_BASE;
  assign hit    = i_set.stb && (offset < 8'd4);

  //////////////////////////////
  // front-end registers
  //////////////////////////////

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_bandsel <= '0;
      o_leds    <= '0;
      o_db_gpio <= '0;
    end else if (hit) begin
      case (offset)
        `SR_RADIO_MISC: o_bandsel <= i_set.data[9:0];
        `SR_RADIO_LEDS: o_leds    <= i_set.data[2:0];
        `SR_RADIO_GPIO: o_db_gpio <= i_set.data;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // spi request slot
  //////////////////////////////

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      req_valid <= 1'b0;
      rx_word   <= '0;
    end else if (i_spi_rsp.done) begin
      // transfer finished, slot free again
      req_valid <= 1'b0;
      rx_word   <= i_spi_rsp.rdata;
    end else if (hit && (offset == `SR_RADIO_SPI) && !req_valid) begin
      req_valid <= 1'b1;
    end
  end

  // word only captured into a free slot, a write while busy is lost
  always_ff @(posedge i_bus_clk) begin
    if (hit && (offset == `SR_RADIO_SPI) && !req_valid) begin
      req_wdata <= i_set.data[15:0];
    end
  end

  assign o_spi_req = '{valid: req_valid, wdata: req_wdata};

  // busy on top, last received word below
  assign o_rb_word = {req_valid, 15'd0, rx_word};

endmodule

/* rtl/spi_arbiter.sv */
/*
 * Round-robin arbiter for the two radio SPI requests in front of the shared
 * engine. Holds the owner of the transfer in flight and returns done to it.
 */
`timescale 1ns/1ns

module spi_arbiter
  import e300_ctrl_pkg::*;
(
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  input  spi_req_t  i_req0,
  input  spi_req_t  i_req1,
  input  logic      i_engine_idle,
  input  spi_rsp_t  i_rsp,
  output logic      o_grant,
  output spi_word_t o_grant_data,
  output spi_rsp_t  o_rsp0,
  output spi_rsp_t  o_rsp1
);

  logic last_winner;
  logic owner;
  logic in_flight;
  logic pick;

  // alternate on contention, otherwise take whoever asks
  assign pick = (i_req0.valid && i_req1.valid) ? ~last_winner : i_req1.valid;

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_grant     <= 1'b0;
      in_flight   <= 1'b0;
      owner       <= 1'b0;
      // radio 0 first after reset
      last_winner <= 1'b1;
    end else begin
      o_grant <= 1'b0;
      if (i_rsp.done) begin
        in_flight <= 1'b0;
      end else if (!in_flight && i_engine_idle && (i_req0.valid || i_req1.valid)) begin
        // granted request stays masked until its done comes back
        o_grant     <= 1'b1;
        in_flight   <= 1'b1;
        owner       <= pick;
        last_winner <= pick;
      end
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (!in_flight) begin
      o_grant_data <= pick ? i_req1.wdata : i_req0.wdata;
    end
  end

  // done goes only to the owner
  assign o_rsp0 = '{done: i_rsp.done && !owner, rdata: i_rsp.rdata};
  assign o_rsp1 = '{done: i_rsp.done && owner, rdata: i_rsp.rdata};

endmodule

/* rtl/spi_engine.sv */
/*
 * Shared SPI master. Shifts one 16-bit word out MSB first and one word in,
 * then pulses done with the received word. Mode 0, sclk idles low.
 */
`timescale 1ns/1ns
`include "e300_ctrl_consts.svh"

module spi_engine
  import e300_ctrl_pkg::*;
(
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  input  logic      i_grant,
  input  spi_word_t i_grant_data,
  input  logic      i_spi_miso,
  output logic      o_idle,
  output spi_rsp_t  o_rsp,
  output logic      o_spi_sen,
  output logic      o_spi_sclk,
  output logic      o_spi_mosi
);

  localparam int DIV   = `SPI_CLKDIV;
  localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

  spi_state_e       state;
  logic [CNT_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  spi_word_t        tx_shift;
  spi_word_t        rx_shift;
  logic             half_done;
  logic             done_q;

  assign half_done = (div_cnt == CNT_W'(DIV - 1));

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      state      <= idle;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      o_spi_sen  <= 1'b1;
      o_spi_sclk <= 1'b0;
      o_spi_mosi <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q  <= 1'b0;
      div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      case (state)
        idle: begin
          div_cnt <= '0;
          if (i_grant) begin
            bit_cnt    <= '0;
            o_spi_sen  <= 1'b0;
            o_spi_mosi <= i_grant_data[15];
            state      <= shift_lo;
          end
        end
        shift_lo: if (half_done) begin
          o_spi_sclk <= 1'b1;
          state      <= shift_hi;
        end
        shift_hi: if (half_done) begin
          // falling edge, next bit onto mosi
          o_spi_sclk <= 1'b0;
          if (bit_cnt == 4'd15) begin
            state <= finish;
          end else begin
            bit_cnt    <= bit_cnt + 1'b1;
            o_spi_mosi <= tx_shift[14];
            state      <= shift_lo;
          end
        end
        finish: begin
          o_spi_sen  <= 1'b1;
          o_spi_mosi <= 1'b0;
          done_q     <= 1'b1;
          state      <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // data shifters
  always_ff @(posedge i_bus_clk) begin
    if (state == idle && i_grant) begin
      tx_shift <= i_grant_data;
    end else if (state == shift_hi && half_done) begin
      tx_shift <= {tx_shift[14:0], 1'b0};
    end
    if (state == shift_lo && half_done) begin
      rx_shift <= {rx_shift[14:0], i_spi_miso};
    end
  end

  assign o_rsp  = '{done: done_q, rdata: rx_shift};
  assign o_idle = (state == idle);

endmodule

/* rtl/e300_ctrl_core.sv */
/*
 * Control-plane top: global registers, two radio blocks, the SPI arbiter
 * and the shared SPI engine. Wiring only.
 */
`timescale 1ns/1ns
`include "e300_ctrl_consts.svh"

module e300_ctrl_core
  import e300_ctrl_pkg::*;
(
  input  logic       i_bus_clk,
  input  logic       i_bus_rst,
  input  set_bus_t   i_set,
  input  logic [1:0] i_lock_signals,
  input  logic [3:0] i_tcxo_status,
  input  logic       i_spi_miso,
  output reg_word_t  o_rb_data,
  output logic [1:0] o_pps_select,
  output logic       o_mimo,
  output logic       o_codec_arst,
  output logic [2:0] o_tx_bandsel,
  output logic [6:0] o_rx1_bandsel,
  output logic [6:0] o_rx2_bandsel,
  output logic [2:0] o_leds0,
  output logic [2:0] o_leds1,
  output reg_word_t  o_db_gpio0,
  output reg_word_t  o_db_gpio1,
  output logic       o_spi_sen,
  output logic       o_spi_sclk,
  output logic       o_spi_mosi
);

  reg_word_t  radio0_rb, radio1_rb;
  logic [9:0] bandsel0, bandsel1;
  spi_req_t   req0, req1;
  spi_rsp_t   rsp0, rsp1, engine_rsp;
  logic       grant, engine_idle;
  spi_word_t  grant_data;

  core_regs core_regs_i (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_set(i_set),
    .i_lock_signals(i_lock_signals), .i_tcxo_status(i_tcxo_status),
    .i_radio0_rb(radio0_rb), .i_radio1_rb(radio1_rb),
    .o_pps_select(o_pps_select), .o_mimo(o_mimo), .o_codec_arst(o_codec_arst),
    .o_rb_data(o_rb_data)
  );

  //////////////////////////////
  // radios
  //////////////////////////////

  radio_ctrl #(.RADIO_BASE(`SR_RADIO0_BASE)) radio0 (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_set(i_set), .i_spi_rsp(rsp0),
    .o_spi_req(req0), .o_bandsel(bandsel0), .o_leds(o_leds0),
    .o_db_gpio(o_db_gpio0), .o_rb_word(radio0_rb)
  );

  radio_ctrl #(.RADIO_BASE(`SR_RADIO1_BASE)) radio1 (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_set(i_set), .i_spi_rsp(rsp1),
    .o_spi_req(req1), .o_bandsel(bandsel1), .o_leds(o_leds1),
    .o_db_gpio(o_db_gpio1), .o_rb_word(radio1_rb)
  );

  // tx band select owned by radio 0
  assign o_tx_bandsel  = bandsel0[2:0];
  assign o_rx1_bandsel = bandsel0[9:3];
  assign o_rx2_bandsel = bandsel1[9:3];

  //////////////////////////////
  // shared spi
  //////////////////////////////

  spi_arbiter spi_arbiter_i (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_req0(req0), .i_req1(req1),
    .i_engine_idle(engine_idle), .i_rsp(engine_rsp),
    .o_grant(grant), .o_grant_data(grant_data), .o_rsp0(rsp0), .o_rsp1(rsp1)
  );

  spi_engine spi_engine_i (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_grant(grant),
    .i_grant_data(grant_data), .i_spi_miso(i_spi_miso),
    .o_idle(engine_idle), .o_rsp(engine_rsp),
    .o_spi_sen(o_spi_sen), .o_spi_sclk(o_spi_sclk), .o_spi_mosi(o_spi_mosi)
  );

endmodule

/* verification/e300_ctrl_tb.sv */
/*
 * Self-checking testbench for e300_ctrl_core. Random register traffic, lock and
 * status inputs and SPI bursts run against a register model and an SPI slave.
 */
`timescale 1ns/1ns
`include "e300_ctrl_consts.svh"

module e300_ctrl_tb
  import e300_ctrl_pkg::*;
();

  localparam int N_REG      = 400;
  localparam int N_LOCK     = 60;
  localparam int N_TCXO     = 20;
  localparam int N_BURST    = 24;
  localparam int POLL_LIMIT = 100;
  // two 66-cycle transfers per burst with polling slack, then the register phases
  localparam int TIMEOUT_CYCLES = N_BURST * 2 * (66 + 20) + N_REG * 3 + N_LOCK +
                                  N_TCXO * 2 + 500;

  logic       bus_clk = 1'b0;
  logic       bus_rst;
  set_bus_t   set_beat;
  logic [1:0] lock_in;
  logic [3:0] tcxo;
  logic       spi_miso = 1'b0;
  reg_word_t  rb_data, db_gpio0, db_gpio1;
  logic [1:0] pps_select;
  logic       mimo, codec_arst, spi_sen, spi_sclk, spi_mosi;
  logic [2:0] tx_bandsel, leds0, leds1;
  logic [6:0] rx1_bandsel, rx2_bandsel;

  // model state
  logic [31:0] lfsr = 32'h8adc_8d8e;
  set_addr_t   m_rbaddr;
  reg_word_t   m_test, m_misc;
  logic [9:0]  m_bandsel [2];
  logic [2:0]  m_leds [2];
  reg_word_t   m_gpio [2];
  logic        m_busy [2];
  spi_word_t   m_last [2];
  spi_word_t   m_rx [2];
  spi_word_t   exp_q [$];
  spi_word_t   mon_q [$];
  spi_word_t   mon_word = '0;
  int          mon_bits = 0;
  logic        sclk_prev = 1'b0;
  logic        sen_prev = 1'b1;

  always #2 bus_clk = ~bus_clk;

  e300_ctrl_core dut (
    .i_bus_clk(bus_clk), .i_bus_rst(bus_rst), .i_set(set_beat),
    .i_lock_signals(lock_in), .i_tcxo_status(tcxo), .i_spi_miso(spi_miso),
    .o_rb_data(rb_data), .o_pps_select(pps_select), .o_mimo(mimo),
    .o_codec_arst(codec_arst), .o_tx_bandsel(tx_bandsel),
    .o_rx1_bandsel(rx1_bandsel), .o_rx2_bandsel(rx2_bandsel),
    .o_leds0(leds0), .o_leds1(leds1), .o_db_gpio0(db_gpio0), .o_db_gpio1(db_gpio1),
    .o_spi_sen(spi_sen), .o_spi_sclk(spi_sclk), .o_spi_mosi(spi_mosi)
  );

  //////////////////////////////
  // spi slave and monitor
  //////////////////////////////

  // slave answers with the inverse of the current mosi bit
  always @(negedge bus_clk) begin
    spi_miso <= ~spi_mosi;
  end

  always @(negedge bus_clk) begin
    if (spi_sen && !sen_prev && mon_bits != 16) begin
      $display("SPI frame ended after %0d bits instead of 16", mon_bits);
      abort_run();
    end else begin
      if (!spi_sen && sen_prev) begin
        mon_bits = 0;
      end
      if (!spi_sen && spi_sclk && !sclk_prev) begin
        mon_word = {mon_word[14:0], spi_mosi};
        mon_bits++;
      end
      if (spi_sen && !sen_prev) begin
        mon_q.push_back(mon_word);
      end
      sclk_prev = spi_sclk;
      sen_prev  = spi_sen;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic set_addr_t spi_addr(input int r);
    return (r == 1) ? (`SR_RADIO1_BASE + `SR_RADIO_SPI) : (`SR_RADIO0_BASE + `SR_RADIO_SPI);
  endfunction

  function automatic logic is_mapped(input set_addr_t a);
    return a == `SR_CORE_READBACK || a == `SR_CORE_MISC || a == `SR_CORE_TEST ||
           (a >= `SR_RADIO0_BASE && a < `SR_RADIO0_BASE + 8'd4) ||
           (a >= `SR_RADIO1_BASE && a < `SR_RADIO1_BASE + 8'd4);
  endfunction

  function automatic reg_word_t expected_rb();
    case (m_rbaddr)
      `RB_CORE_MISC:   return {26'd0, tcxo, m_misc[1:0]};
      `RB_CORE_COMPAT: return `CORE_COMPAT_VALUE;
      `RB_CORE_PLL:    return {30'd0, lock_in};
      `RB_CORE_TEST:   return m_test;
      `RB_RADIO0_SPI:  return {m_busy[0], 15'd0, m_rx[0]};
      `RB_RADIO1_SPI:  return {m_busy[1], 15'd0, m_rx[1]};
      default:         return `RB_DEFAULT;
    endcase
  endfunction

  task automatic model_reset();
    m_rbaddr = '0;
    m_test   = '0;
    m_misc   = `MISC_RESET;
    for (int r = 0; r < 2; r++) begin
      m_bandsel[r] = '0;
      m_leds[r]    = '0;
      m_gpio[r]    = '0;
      m_busy[r]    = 1'b0;
      m_last[r]    = '0;
      m_rx[r]      = '0;
    end
  endtask

  task automatic model_write(input set_addr_t waddr, input reg_word_t wdata);
    int r;
    r = (waddr >= `SR_RADIO1_BASE) ? 1 : 0;
    case (waddr)
      `SR_CORE_READBACK: m_rbaddr = wdata[7:0];
      `SR_CORE_MISC:     m_misc = wdata;
      `SR_CORE_TEST:     m_test = wdata;
      `SR_RADIO0_BASE + `SR_RADIO_MISC, `SR_RADIO1_BASE + `SR_RADIO_MISC:
        m_bandsel[r] = wdata[9:0];
      `SR_RADIO0_BASE + `SR_RADIO_LEDS, `SR_RADIO1_BASE + `SR_RADIO_LEDS:
        m_leds[r] = wdata[2:0];
      `SR_RADIO0_BASE + `SR_RADIO_GPIO, `SR_RADIO1_BASE + `SR_RADIO_GPIO:
        m_gpio[r] = wdata;
      `SR_RADIO0_BASE + `SR_RADIO_SPI, `SR_RADIO1_BASE + `SR_RADIO_SPI: begin
        // a pending request swallows further writes
        if (!m_busy[r]) begin
          m_busy[r] = 1'b1;
          m_last[r] = wdata[15:0];
          exp_q.push_back(wdata[15:0]);
        end
      end
      default: ;
    endcase
  endtask

  task automatic check_ports();
    check_value("o_rb_data", rb_data, expected_rb());
    check_value("o_pps_select", 32'(pps_select), 32'(m_misc[1:0]));
    check_value("o_mimo", 32'(mimo), 32'(m_misc[2]));
    check_value("o_codec_arst", 32'(codec_arst), 32'(m_misc[3]));
    check_value("o_tx_bandsel", 32'(tx_bandsel), 32'(m_bandsel[0][2:0]));
    check_value("o_rx1_bandsel", 32'(rx1_bandsel), 32'(m_bandsel[0][9:3]));
    check_value("o_rx2_bandsel", 32'(rx2_bandsel), 32'(m_bandsel[1][9:3]));
    check_value("o_leds0", 32'(leds0), 32'(m_leds[0]));
    check_value("o_leds1", 32'(leds1), 32'(m_leds[1]));
    check_value("o_db_gpio0", db_gpio0, m_gpio[0]);
    check_value("o_db_gpio1", db_gpio1, m_gpio[1]);
  endtask

  // one settings beat, returns on the falling edge after the strobe
  task automatic drive_beat(input set_addr_t waddr, input reg_word_t wdata);
    @(negedge bus_clk);
    set_beat = '{stb: 1'b1, addr: waddr, data: wdata};
    @(negedge bus_clk);
    set_beat.stb = 1'b0;
  endtask

  task automatic write_reg(input set_addr_t waddr, input reg_word_t wdata);
    drive_beat(waddr, wdata);
    model_write(waddr, wdata);
    check_ports();
  endtask

  //////////////////////////////
  // test phases
  //////////////////////////////

  task automatic random_registers();
    logic [2:0] kind;
    set_addr_t  waddr;
    reg_word_t  wdata;
    for (int i = 0; i < N_REG; i++) begin
      kind  = 3'(rand_bits(3));
      wdata = rand_bits(32);
      case (kind)
        3'd0: waddr = `SR_CORE_TEST;
        3'd1: waddr = `SR_CORE_MISC;
        3'd2: begin
          waddr = `SR_CORE_READBACK;
          case (3'(rand_bits(3)))
            3'd0: wdata[7:0] = `RB_CORE_MISC;
            3'd1: wdata[7:0] = `RB_CORE_TEST;
            3'd2: wdata[7:0] = `RB_RADIO0_SPI;
            3'd3: wdata[7:0] = `RB_RADIO1_SPI;
            3'd4: wdata[7:0] = `RB_CORE_COMPAT;
            default: ;
          endcase
        end
        3'd3: begin
          waddr = 8'(rand_bits(8));
          while (is_mapped(waddr)) waddr = 8'(rand_bits(8));
        end
        default: begin
          waddr = (rand_bits(1) == 32'd1) ? `SR_RADIO1_BASE : `SR_RADIO0_BASE;
          waddr = waddr + 8'(rand_bits(2) % 32'd3);
        end
      endcase
      write_reg(waddr, wdata);
    end
  endtask

  task automatic lock_and_status();
    logic [1:0] hist1;
    logic [1:0] hist2;
    write_reg(`SR_CORE_READBACK, 32'(`RB_CORE_PLL));
    hist1 = lock_in;
    hist2 = lock_in;
    // each value must show up exactly two cycles after it was driven
    for (int i = 0; i < N_LOCK; i++) begin
      @(negedge bus_clk);
      check_value("o_rb_data pll", rb_data, {30'd0, hist2});
      hist2   = hist1;
      hist1   = 2'(rand_bits(2));
      lock_in = hist1;
    end
    repeat (2) @(negedge bus_clk);
    check_ports();
    write_reg(`SR_CORE_READBACK, 32'(`RB_CORE_MISC));
    for (int i = 0; i < N_TCXO; i++) begin
      @(negedge bus_clk);
      tcxo = 4'(rand_bits(4));
      @(negedge bus_clk);
      check_ports();
    end
  endtask

  task automatic wait_spi_idle();
    int   polls;
    logic busy0;
    logic busy1;
    polls = 0;
    busy0 = 1'b1;
    busy1 = 1'b1;
    while (busy0 || busy1) begin
      if (polls == POLL_LIMIT) begin
        $display("SPI busy bits still set after %0d polls", polls);
        abort_run();
      end
      drive_beat(`SR_CORE_READBACK, 32'(`RB_RADIO0_SPI));
      busy0 = rb_data[31];
      drive_beat(`SR_CORE_READBACK, 32'(`RB_RADIO1_SPI));
      busy1 = rb_data[31];
      polls++;
    end
    m_rbaddr = `RB_RADIO1_SPI;
    for (int r = 0; r < 2; r++) begin
      if (m_busy[r]) begin
        m_rx[r] = ~m_last[r];
      end
      m_busy[r] = 1'b0;
    end
  endtask

  task automatic spi_bursts();
    int n;
    for (int b = 0; b < N_BURST; b++) begin
      write_reg(`SR_CORE_READBACK,
                (rand_bits(1) == 32'd1) ? 32'(`RB_RADIO1_SPI) : 32'(`RB_RADIO0_SPI));
      if (b == 0) begin
        // radio 0 first out of reset, then radio 1, then a write while busy
        write_reg(spi_addr(0), rand_bits(32));
        write_reg(spi_addr(1), rand_bits(32));
        write_reg(spi_addr(0), rand_bits(32));
      end else begin
        n = 1 + int'(rand_bits(2));
        for (int i = 0; i < n; i++) begin
          write_reg(spi_addr(int'(rand_bits(1))), rand_bits(32));
        end
      end
      wait_spi_idle();
      check_value("spi transfer count", 32'(mon_q.size()), 32'(exp_q.size()));
      foreach (exp_q[i]) begin
        check_value("o_spi_mosi word", 32'(mon_q[i]), 32'(exp_q[i]));
      end
      mon_q.delete();
      exp_q.delete();
      check_ports();
      write_reg(`SR_CORE_READBACK, 32'(`RB_RADIO0_SPI));
      check_value("o_spi_sen", 32'(spi_sen), 32'd1);
    end
  endtask

  //////////////////////////////
  // main sequence and watchdog
  //////////////////////////////

  initial begin
    set_beat = '0;
    lock_in  = 2'b00;
    tcxo     = 4'h0;
    bus_rst  = 1'b1;
    model_reset();
    repeat (8) @(negedge bus_clk);
    bus_rst = 1'b0;
    @(negedge bus_clk);

    // reset state, readback select starts on an unlisted address
    check_ports();
    check_value("o_spi_sen", 32'(spi_sen), 32'd1);
    check_value("o_spi_sclk", 32'(spi_sclk), 32'd0);
    check_value("o_spi_mosi", 32'(spi_mosi), 32'd0);
    write_reg(`SR_CORE_READBACK, 32'(`RB_CORE_MISC));
    write_reg(`SR_CORE_READBACK, 32'(`RB_CORE_COMPAT));
    write_reg(`SR_CORE_READBACK, 32'h0000_0009);

    random_registers();
    lock_and_status();
    spi_bursts();

    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 4);
    $display("watchdog expired after %0d cycles before the tests finished", TIMEOUT_CYCLES);
    abort_run();
  end

endmodule

/* e300_ctrl.f */
+incdir+rtl
rtl/e300_ctrl_pkg.sv
rtl/core_regs.sv
rtl/radio_ctrl.sv
rtl/spi_arbiter.sv
rtl/spi_engine.sv
rtl/e300_ctrl_core.sv
verification/e300_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := e300_ctrl_tb
RTL_TOP   := e300_ctrl_core
FILELIST  := e300_ctrl.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
